/* common/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;

    ////////////////////
    // address split
    ////////////////////
    // word address, line = tag | l2 index | word select
    localparam int addr_w     = 28;
    localparam int word_sel_w = 2;   // addr[1:0]
    localparam int l2_index_w = 9;   // addr[10:2]
    localparam int l2_tag_w   = 17;  // addr[27:11]
    localparam int l1_index_w = 8;   // addr[9:2]
    localparam int l1_tag_w   = 18;  // addr[27:10]
    localparam int mem_addr_w = l2_tag_w + l2_index_w;  // line address into memory

    ////////////////////
    // data and ways
    ////////////////////
    localparam int line_w         = 512;
    localparam int word_w         = 128;
    localparam int words_per_line = line_w / word_w;
    localparam int l2_ways        = 4;
    localparam int l1_ways        = 2;
    localparam int l2_way_w       = $clog2(l2_ways);
    localparam int l1_way_w       = $clog2(l1_ways);

    localparam logic rw_read = 1'b0;  // write requests carry 1

    ////////////////////
    // types
    ////////////////////
    typedef struct packed {
        logic                rw;
        logic [addr_w-1:0]   addr;
        logic [l2_way_w-1:0] l2_way;
        logic [l1_way_w-1:0] l1_way;
        logic                ic_en;
        logic                dc_en;
    } mem_req_t;

    // L2 read side for the set being replaced
    typedef struct packed {
        logic [l2_ways-1:0]                valid;
        logic [l2_ways-1:0][l2_tag_w-1:0]  tag;
        logic [l2_ways-1:0][line_w-1:0]    line;
    } l2_victim_t;

    // memory sees a flat line, refill picks one word of it
    typedef union packed {
        logic [line_w-1:0]                     flat;
        logic [words_per_line-1:0][word_w-1:0] word;
    } line_u;

    typedef struct packed {
        logic                  valid;
        logic [l1_tag_w-1:0]   tag;
    } l1_tag_t;

    typedef struct packed {
        logic                  valid;
        logic [l2_tag_w-1:0]   tag;
    } l2_tag_t;

    typedef struct packed {
        logic [l1_ways-1:0]    we;     // one per L1 way
        logic [l1_index_w-1:0] index;
        l1_tag_t               tag;
        logic [word_w-1:0]     data;
    } l1_fill_t;

    typedef struct packed {
        logic [l2_ways-1:0]    way_we;
        logic [l2_index_w-1:0] index;
        l2_tag_t               tag;
        line_u                 line;
    } l2_fill_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        COMMIT
    } miss_state_e;

endpackage

/* miss_fsm/miss_fsm.sv */
`timescale 1ns/100ps

module miss_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic access_clean,
    input  logic access_dirty,
    input  logic mem_complete_r,
    input  logic mem_complete_w,
    input  logic l2_complete_w,
    output logic mem_re,
    output logic mem_we,
    output logic busy,
    output logic mem_access_complete,
    output logic capture,
    output logic to_refill,
    output logic line_arrived,
    output logic commit_done
);

    mem_ctrl_pkg::miss_state_e state;
    mem_ctrl_pkg::miss_state_e state_next;

    ////////////////////
    // strobes to the datapath
    ////////////////////
    // each one is qualified by the state, so a stray completion does nothing
    assign capture      = (state == mem_ctrl_pkg::IDLE) && (access_clean || access_dirty);
    assign to_refill    = (state == mem_ctrl_pkg::WRITEBACK) && mem_complete_w;
    assign line_arrived = (state == mem_ctrl_pkg::REFILL) && mem_complete_r;
    assign commit_done  = (state == mem_ctrl_pkg::COMMIT) && l2_complete_w;

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_next = state;
        case (state)
            mem_ctrl_pkg::IDLE: begin
                // dirty wins since the victim has to leave first
                if (access_dirty) begin
                    state_next = mem_ctrl_pkg::WRITEBACK;
                end else if (access_clean) begin
                    state_next = mem_ctrl_pkg::REFILL;
                end
            end
            mem_ctrl_pkg::WRITEBACK: begin
                if (mem_complete_w) begin
                    state_next = mem_ctrl_pkg::REFILL;
                end
            end
            mem_ctrl_pkg::REFILL: begin
                if (mem_complete_r) begin
                    state_next = mem_ctrl_pkg::COMMIT;  // line is with the router now
                end
            end
            mem_ctrl_pkg::COMMIT: begin
                if (l2_complete_w) begin
                    state_next = mem_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_next = mem_ctrl_pkg::IDLE;
            end
        endcase
    end

    ////////////////////
    // state and registered outputs
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state               <= mem_ctrl_pkg::IDLE;
            mem_re              <= 1'b0;
            mem_we              <= 1'b0;
            busy                <= 1'b0;
            mem_access_complete <= 1'b0;
        end else begin
            state               <= state_next;
            mem_access_complete <= commit_done;  // single cycle by construction

            if (capture) begin
                busy   <= 1'b1;
                mem_we <= access_dirty;
                mem_re <= !access_dirty;
            end

            // the new line is read straight after the writeback
            if (to_refill) begin
                mem_we <= 1'b0;
                mem_re <= 1'b1;
            end

            if (line_arrived) begin
                mem_re <= 1'b0;
            end

            if (commit_done) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////
    // memory sees one command at a time
    mem_cmd_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_re && mem_we)
    );

    complete_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_access_complete |=> !mem_access_complete
    );

    // no memory command outside a busy frame
    cmd_inside_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_re || mem_we) |-> busy
    );

endmodule

/* design/writeback_buffer.sv */
`timescale 1ns/100ps

module writeback_buffer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  mem_ctrl_pkg::mem_req_t              req,
    input  mem_ctrl_pkg::l2_victim_t            victim,
    input  logic                                capture,
    input  logic                                dirty,
    input  logic                                to_refill,
    output mem_ctrl_pkg::mem_req_t              held_req,
    output logic [mem_ctrl_pkg::mem_addr_w-1:0] mem_addr,
    output mem_ctrl_pkg::line_u                 mem_wd
);

    logic [mem_ctrl_pkg::l2_way_w-1:0]   way;
    logic                                wb_needed;
    logic [mem_ctrl_pkg::mem_addr_w-1:0] victim_addr;
    logic [mem_ctrl_pkg::mem_addr_w-1:0] refill_addr;
    logic [mem_ctrl_pkg::mem_addr_w-1:0] held_refill_addr;

    assign way = req.l2_way;

    // an invalid way has no stored tag, so only the refill line is addressed
    assign wb_needed = dirty && victim.valid[way];

    // victim lives in the same set, only the tag differs
    assign victim_addr = {
        victim.tag[way],
        req.addr[mem_ctrl_pkg::word_sel_w +: mem_ctrl_pkg::l2_index_w]
    };
    assign refill_addr      = req.addr[mem_ctrl_pkg::addr_w-1:mem_ctrl_pkg::word_sel_w];
    assign held_refill_addr = held_req.addr[mem_ctrl_pkg::addr_w-1:mem_ctrl_pkg::word_sel_w];

    ////////////////////
    // request and address
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_req <= '0;
            mem_addr <= '0;
        end else if (capture) begin
            held_req <= req;
            mem_addr <= wb_needed ? victim_addr : refill_addr;
        end else if (to_refill) begin
            mem_addr <= held_refill_addr;  // swap to the missing line
        end
    end

    // victim line, held through the writeback
    always_ff @(posedge clk) begin
        if (capture) begin
            mem_wd.flat <= victim.line[way];
        end
    end

endmodule

/* design/refill_router.sv */
`timescale 1ns/100ps

module refill_router (
    input  logic                   clk,
    input  logic                   arst_n,
    input  mem_ctrl_pkg::mem_req_t held_req,
    input  mem_ctrl_pkg::line_u    mem_rd,
    input  logic                   line_arrived,
    input  logic                   commit_done,
    output mem_ctrl_pkg::l2_fill_t l2_fill,
    output mem_ctrl_pkg::l1_fill_t ic_fill,
    output mem_ctrl_pkg::l1_fill_t dc_fill
);

    logic [mem_ctrl_pkg::l2_ways-1:0]    l2_way_dec;
    logic [mem_ctrl_pkg::l1_ways-1:0]    l1_way_dec;
    logic                                rd_fill;  // read miss, L1 takes the word

    // control
    logic [mem_ctrl_pkg::l2_ways-1:0]    way_we;
    logic [mem_ctrl_pkg::l1_ways-1:0]    ic_we;
    logic [mem_ctrl_pkg::l1_ways-1:0]    dc_we;

    // payload
    mem_ctrl_pkg::line_u                 fill_line;
    logic [mem_ctrl_pkg::word_w-1:0]     fill_word;
    logic [mem_ctrl_pkg::l2_index_w-1:0] l2_index;
    mem_ctrl_pkg::l2_tag_t               l2_tag;
    logic [mem_ctrl_pkg::l1_index_w-1:0] l1_index;
    mem_ctrl_pkg::l1_tag_t               l1_tag;

    always_comb begin
        l2_way_dec                  = '0;
        l2_way_dec[held_req.l2_way] = 1'b1;
        l1_way_dec                  = '0;
        l1_way_dec[held_req.l1_way] = 1'b1;
    end

    assign rd_fill = (held_req.rw == mem_ctrl_pkg::rw_read);

    ////////////////////
    // enables
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            way_we <= '0;
            ic_we  <= '0;
            dc_we  <= '0;
        end else begin
            ic_we <= '0;  // L1 fills are pulses
            dc_we <= '0;
            if (line_arrived) begin
                way_we <= l2_way_dec;  // held until L2 acks
                ic_we  <= (rd_fill && held_req.ic_en) ? l1_way_dec : '0;
                dc_we  <= (rd_fill && held_req.dc_en) ? l1_way_dec : '0;
            end else if (commit_done) begin
                way_we <= '0;
            end
        end
    end

    ////////////////////
    // line, word and tags
    ////////////////////
    always_ff @(posedge clk) begin
        if (line_arrived) begin
            fill_line <= mem_rd;
            fill_word <= mem_rd.word[held_req.addr[mem_ctrl_pkg::word_sel_w-1:0]];
            l2_index  <= held_req.addr[mem_ctrl_pkg::word_sel_w +: mem_ctrl_pkg::l2_index_w];
            l2_tag    <= {1'b1, held_req.addr[mem_ctrl_pkg::addr_w-1 -: mem_ctrl_pkg::l2_tag_w]};
            l1_index  <= held_req.addr[mem_ctrl_pkg::word_sel_w +: mem_ctrl_pkg::l1_index_w];
            l1_tag    <= {1'b1, held_req.addr[mem_ctrl_pkg::addr_w-1 -: mem_ctrl_pkg::l1_tag_w]};
        end
    end

    assign l2_fill = '{way_we: way_we, index: l2_index, tag: l2_tag, line: fill_line};

    // both L1s see the same word, only the enables differ
    assign ic_fill = '{we: ic_we, index: l1_index, tag: l1_tag, data: fill_word};
    assign dc_fill = '{we: dc_we, index: l1_index, tag: l1_tag, data: fill_word};

    ////////////////////
    // checks
    ////////////////////
    way_we_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(l2_fill.way_we)
    );

    // an L1 fill only goes out in the cycle the L2 write starts
    l1_fill_with_l2: assert property (
        @(posedge clk) disable iff (!arst_n)
        (|ic_fill.we || |dc_fill.we) |-> $rose(|l2_fill.way_we)
    );

endmodule

/* design/mem_ctrl_top.sv */
`timescale 1ns/100ps

module mem_ctrl_top (
    input  logic                                 clk,
    input  logic                                 arst_n,
    // request side from L2 control
    input  mem_ctrl_pkg::mem_req_t               req,
    input  logic                                 access_clean,
    input  logic                                 access_dirty,
    input  mem_ctrl_pkg::l2_victim_t             victim,
    // memory
    input  logic                                 mem_complete_r,
    input  logic                                 mem_complete_w,
    input  mem_ctrl_pkg::line_u                  mem_rd,
    output logic                                 mem_re,
    output logic                                 mem_we,
    output logic [mem_ctrl_pkg::mem_addr_w-1:0]  mem_addr,
    output mem_ctrl_pkg::line_u                  mem_wd,
    // cache fills
    input  logic                                 l2_complete_w,
    output mem_ctrl_pkg::l2_fill_t               l2_fill,
    output mem_ctrl_pkg::l1_fill_t               ic_fill,
    output mem_ctrl_pkg::l1_fill_t               dc_fill,
    // status
    output logic                                 busy,
    output logic                                 mem_access_complete
);

    logic                   capture;       // request taken in idle
    logic                   to_refill;     // writeback done, present refill line
    logic                   line_arrived;
    logic                   commit_done;
    mem_ctrl_pkg::mem_req_t held_req;

    miss_fsm u_miss_fsm (
        .clk                 (clk),
        .arst_n              (arst_n),
        .access_clean        (access_clean),
        .access_dirty        (access_dirty),
        .mem_complete_r      (mem_complete_r),
        .mem_complete_w      (mem_complete_w),
        .l2_complete_w       (l2_complete_w),
        .mem_re              (mem_re),
        .mem_we              (mem_we),
        .busy                (busy),
        .mem_access_complete (mem_access_complete),
        .capture             (capture),
        .to_refill           (to_refill),
        .line_arrived        (line_arrived),
        .commit_done         (commit_done)
    );

    // dirty only steers the first address here
    writeback_buffer u_writeback_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .victim    (victim),
        .capture   (capture),
        .dirty     (access_dirty),
        .to_refill (to_refill),
        .held_req  (held_req),
        .mem_addr  (mem_addr),
        .mem_wd    (mem_wd)
    );

    refill_router u_refill_router (
        .clk          (clk),
        .arst_n       (arst_n),
        .held_req     (held_req),
        .mem_rd       (mem_rd),
        .line_arrived (line_arrived),
        .commit_done  (commit_done),
        .l2_fill      (l2_fill),
        .ic_fill      (ic_fill),
        .dc_fill      (dc_fill)
    );

endmodule

/* testbench/tb_mem_model.sv */
`timescale 1ns/100ps

module tb_mem_model (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                mem_re,
    input  logic                                mem_we,
    input  logic [mem_ctrl_pkg::mem_addr_w-1:0] mem_addr,
    output mem_ctrl_pkg::line_u                 mem_rd,
    output logic                                mem_complete_r,
    output logic                                mem_complete_w,
    input  mem_ctrl_pkg::l2_fill_t              l2_fill,
    output logic                                l2_complete_w
);

    integer seed = 32'h5220_601a;
    int     mem_wait;
    int     l2_wait;
    logic   is_read;

    // every word depends on the whole line address and its position
    function automatic logic [mem_ctrl_pkg::line_w-1:0] line_data(
        input logic [mem_ctrl_pkg::mem_addr_w-1:0] line_addr
    );
        logic [mem_ctrl_pkg::line_w-1:0] l;
        logic [31:0]                     h;
        for (int i = 0; i < 4; i++) begin
            h = {6'd0, line_addr} * 32'h9e37_79b1 + i;
            l[i*128 +: 128] = {~h, h ^ 32'h5a5a_a5a5, {line_addr, 6'(i)}, h};
        end
        return l;
    endfunction

    ////////////////////
    // memory responder
    ////////////////////
    initial begin
        mem_rd         = '0;
        mem_complete_r = 1'b0;
        mem_complete_w = 1'b0;
        forever begin
            @(negedge clk);
            if (arst_n && (mem_re || mem_we)) begin
                is_read  = mem_re;
                mem_wait = 1 + {$random(seed)} % 8;  // 1 to 8 cycles
                repeat (mem_wait) @(negedge clk);
                if (is_read) begin
                    mem_rd.flat    = line_data(mem_addr);
                    mem_complete_r = 1'b1;
                end else begin
                    mem_complete_w = 1'b1;
                end
                @(negedge clk);
                mem_complete_r = 1'b0;
                mem_complete_w = 1'b0;
            end
        end
    end

    ////////////////////
    // L2 write ack
    ////////////////////
    initial begin
        l2_complete_w = 1'b0;
        forever begin
            @(negedge clk);
            if (arst_n && |l2_fill.way_we) begin
                l2_wait = 1 + {$random(seed)} % 8;
                repeat (l2_wait) @(negedge clk);
                l2_complete_w = 1'b1;
                @(negedge clk);
                l2_complete_w = 1'b0;  // way enable drops on the next edge
            end
        end
    end

endmodule

/* testbench/tb_mem_ctrl.sv */
`timescale 1ns/100ps

module tb_mem_ctrl;

    localparam int period       = 40;
    localparam int n_random     = 200;
    localparam int n_tests      = 4 + n_random;
    localparam int worst_cycles = 40;  // writeback, refill and commit at 8 cycles each plus slack
    localparam int limit_cycles = 16 + n_tests * worst_cycles + 100;

    typedef struct packed {
        logic                                dirty;
        logic [mem_ctrl_pkg::mem_addr_w-1:0] wb_addr;
        logic [mem_ctrl_pkg::line_w-1:0]     wb_line;
        logic [mem_ctrl_pkg::mem_addr_w-1:0] refill_addr;
        logic [mem_ctrl_pkg::l2_ways-1:0]    way_we;
        logic [mem_ctrl_pkg::l2_index_w-1:0] l2_index;
        mem_ctrl_pkg::l2_tag_t               l2_tag;
        logic [mem_ctrl_pkg::line_w-1:0]     line;
        logic [mem_ctrl_pkg::l1_ways-1:0]    ic_we;
        logic [mem_ctrl_pkg::l1_ways-1:0]    dc_we;
        logic [mem_ctrl_pkg::l1_index_w-1:0] l1_index;
        mem_ctrl_pkg::l1_tag_t               l1_tag;
        logic [mem_ctrl_pkg::word_w-1:0]     word;
    } expect_t;

    logic                                clk;
    logic                                arst_n;
    mem_ctrl_pkg::mem_req_t              req;
    logic                                access_clean;
    logic                                access_dirty;
    mem_ctrl_pkg::l2_victim_t            victim;
    logic                                mem_complete_r;
    logic                                mem_complete_w;
    mem_ctrl_pkg::line_u                 mem_rd;
    logic                                mem_re;
    logic                                mem_we;
    logic [mem_ctrl_pkg::mem_addr_w-1:0] mem_addr;
    mem_ctrl_pkg::line_u                 mem_wd;
    logic                                l2_complete_w;
    mem_ctrl_pkg::l2_fill_t              l2_fill;
    mem_ctrl_pkg::l1_fill_t              ic_fill;
    mem_ctrl_pkg::l1_fill_t              dc_fill;
    logic                                busy;
    logic                                mem_access_complete;

    integer                   seed = 32'h5220_601a;
    string                    test_name;
    expect_t                  expected_miss;
    logic                     in_flight = 1'b0;  // checker's view of the current miss
    logic                     wb_seen = 1'b0;
    logic                     re_seen = 1'b0;
    logic                     fill_seen = 1'b0;
    mem_ctrl_pkg::mem_req_t   r;
    mem_ctrl_pkg::l2_victim_t v;
    logic                     d;

    mem_ctrl_top dut (.*);
    tb_mem_model mem_model (.*);

    always #(period / 2) clk = ~clk;

    ////////////////////
    // reference
    ////////////////////
    function automatic logic [mem_ctrl_pkg::line_w-1:0] expected_line(
        input logic [mem_ctrl_pkg::mem_addr_w-1:0] line_addr
    );
        logic [mem_ctrl_pkg::line_w-1:0] l;
        logic [31:0]                     h;
        for (int i = 0; i < 4; i++) begin
            h = {6'd0, line_addr} * 32'h9e37_79b1 + i;
            l[i*128 +: 128] = {~h, h ^ 32'h5a5a_a5a5, {line_addr, 6'(i)}, h};
        end
        return l;
    endfunction

    // addr = tag[27:11] | index[10:2] | word[1:0] and the L1 tag is [27:10]
    function automatic expect_t predict_miss(input mem_ctrl_pkg::mem_req_t rq,
                                             input mem_ctrl_pkg::l2_victim_t vc,
                                             input logic dirty);
        expect_t    e;
        logic [1:0] l1_sel;
        e.dirty       = dirty;
        e.wb_addr     = {vc.tag[rq.l2_way], rq.addr[10:2]};
        e.wb_line     = vc.line[rq.l2_way];
        e.refill_addr = rq.addr[27:2];
        e.way_we      = 4'b0001 << rq.l2_way;
        e.l2_index    = rq.addr[10:2];
        e.l2_tag      = {1'b1, rq.addr[27:11]};
        e.line        = expected_line(rq.addr[27:2]);
        e.word        = e.line[rq.addr[1:0] * 128 +: 128];
        l1_sel        = 2'b01 << rq.l1_way;
        e.ic_we       = (rq.rw == 1'b0 && rq.ic_en) ? l1_sel : 2'b00;  // writes skip L1
        e.dc_we       = (rq.rw == 1'b0 && rq.dc_en) ? l1_sel : 2'b00;
        e.l1_index    = rq.addr[9:2];
        e.l1_tag      = {1'b1, rq.addr[27:10]};
        return e;
    endfunction

    task automatic check(input string what,
                         input logic [mem_ctrl_pkg::line_w-1:0] expected,
                         input logic [mem_ctrl_pkg::line_w-1:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_l1(input string cache, input mem_ctrl_pkg::l1_fill_t f);
        check({cache, " index"}, expected_miss.l1_index, f.index);
        check({cache, " tag"}, expected_miss.l1_tag, f.tag);
        check({cache, " word"}, expected_miss.word, f.data);
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    task automatic make_random(output mem_ctrl_pkg::mem_req_t rq,
                               output mem_ctrl_pkg::l2_victim_t vc,
                               output logic dirty);
        logic [67*32-1:0] bits;
        logic [63:0]      req_bits;
        for (int i = 0; i < 67; i++) begin
            bits = {bits[66*32-1:0], $random(seed)};
        end
        req_bits = {$random(seed), $random(seed)};
        vc       = bits[$bits(mem_ctrl_pkg::l2_victim_t)-1:0];
        rq       = req_bits[$bits(mem_ctrl_pkg::mem_req_t)-1:0];
        dirty    = req_bits[63];
        if (dirty) begin
            vc.valid[rq.l2_way] = 1'b1;  // a dirty victim always has a stored tag
        end
    endtask

    task automatic run_miss(input string name,
                            input mem_ctrl_pkg::mem_req_t rq,
                            input mem_ctrl_pkg::l2_victim_t vc,
                            input logic dirty);
        @(negedge clk);
        while (busy) @(negedge clk);
        test_name     = name;
        expected_miss = predict_miss(rq, vc, dirty);
        req           = rq;
        victim        = vc;
        access_dirty  = dirty;
        access_clean  = !dirty;
        @(negedge clk);
        access_clean  = 1'b0;
        access_dirty  = 1'b0;
        while (!mem_access_complete) @(negedge clk);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        req          = '0;
        access_clean = 1'b0;
        access_dirty = 1'b0;
        victim       = '0;
        test_name    = "reset";
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check("busy", 0, busy);
        check("mem_re", 0, mem_re);
        check("mem_we", 0, mem_we);
        check("completion", 0, mem_access_complete);
        check("L2 way enable", 0, l2_fill.way_we);
        check("icache fill enable", 0, ic_fill.we);
        check("dcache fill enable", 0, dc_fill.we);

        make_random(r, v, d);
        r.rw    = mem_ctrl_pkg::rw_read;
        r.ic_en = 1'b1;
        r.dc_en = 1'b0;
        run_miss("clean read to icache", r, v, 1'b0);

        make_random(r, v, d);
        r.rw              = mem_ctrl_pkg::rw_read;
        r.ic_en           = 1'b1;
        r.dc_en           = 1'b0;
        v.valid[r.l2_way] = 1'b1;
        run_miss("dirty read", r, v, 1'b1);

        make_random(r, v, d);
        r.rw    = 1'b1;
        r.ic_en = 1'b1;
        r.dc_en = 1'b1;
        run_miss("write request", r, v, 1'b0);

        make_random(r, v, d);
        r.rw     = mem_ctrl_pkg::rw_read;
        r.ic_en  = 1'b0;
        r.dc_en  = 1'b1;
        r.l1_way = 1'b1;
        run_miss("read to dcache way 1", r, v, 1'b0);

        for (int i = 0; i < n_random; i++) begin
            make_random(r, v, d);
            run_miss($sformatf("random %0d", i), r, v, d);
        end

        repeat (4) @(negedge clk);
        $display("No errors");
        $finish;
    end

    ////////////////////
    // checker
    ////////////////////
    always @(negedge clk) begin
        if (arst_n) begin
            if (busy && !in_flight) begin  // a new miss has started
                in_flight = 1'b1;
                wb_seen   = 1'b0;
                re_seen   = 1'b0;
                fill_seen = 1'b0;
            end
            if (mem_we && !wb_seen) begin
                wb_seen = 1'b1;
                check("writeback address", expected_miss.wb_addr, mem_addr);
                check("writeback line", expected_miss.wb_line, mem_wd.flat);
            end
            if (mem_re && !re_seen) begin
                re_seen = 1'b1;
                check("writeback before read", expected_miss.dirty, wb_seen);
                check("mem_we during read", 0, mem_we);
                check("refill address", expected_miss.refill_addr, mem_addr);
            end
            if (|l2_fill.way_we && !fill_seen) begin
                fill_seen = 1'b1;
                check("mem_re after refill", 0, mem_re);
                check("L2 index", expected_miss.l2_index, l2_fill.index);
                check("L2 tag", expected_miss.l2_tag, l2_fill.tag);
                check("L2 line", expected_miss.line, l2_fill.line.flat);
                check("icache fill enable", expected_miss.ic_we, ic_fill.we);
                check("dcache fill enable", expected_miss.dc_we, dc_fill.we);
                if (|expected_miss.ic_we) begin
                    check_l1("icache", ic_fill);
                end
                if (|expected_miss.dc_we) begin
                    check_l1("dcache", dc_fill);
                end
            end else begin
                // L1 fills only in the first cycle of the L2 write
                check("icache fill pulse", 0, ic_fill.we);
                check("dcache fill pulse", 0, dc_fill.we);
            end
            // way enable stays up until L2 acks
            if (in_flight && fill_seen && !mem_access_complete) begin
                check("L2 way enable", expected_miss.way_we, l2_fill.way_we);
            end
            if (mem_access_complete) begin
                check("completion inside a miss", 1, in_flight);
                check("line filled before completion", 1, fill_seen);
                check("busy at completion", 0, busy);
                check("L2 way enable at completion", 0, l2_fill.way_we);
                in_flight = 1'b0;
            end
        end
    end

    // watchdog
    initial begin
        #(limit_cycles * period);
        $display("DUT hung: %s did not complete within %0d cycles", test_name, limit_cycles);
        $display("Errors found");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* mem_ctrl.f */
common/mem_ctrl_pkg.sv
miss_fsm/miss_fsm.sv
design/writeback_buffer.sv
design/refill_router.sv
design/mem_ctrl_top.sv
testbench/tb_mem_model.sv
testbench/tb_mem_ctrl.sv
